// File: verilog/isa_pkg.sv
// ##########################################################
// pipe16 instruction set: word types, opcode encoding and
// instruction field positions shared by the core
// ##########################################################
package isa_pkg;

   localparam int WORD_W    = 16;
   localparam int NUM_REGS  = 8;
   localparam int REG_IDX_W = $clog2(NUM_REGS);

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // 4'hC..4'hF are illegal
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,   // All-zero word, also the pipeline bubble
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LBI  = 4'h6,
      OP_LD   = 4'h7,
      OP_ST   = 4'h8,
      OP_BEQZ = 4'h9,
      OP_BNEZ = 4'hA,
      OP_HALT = 4'hB
   } opcode_t;

   // Field positions by lsb
   localparam int OPC_LSB = 12;
   localparam int OPC_W   = 4;
   localparam int RD_LSB  = 9;
   localparam int RS_LSB  = 6;
   localparam int RT_LSB  = 3;
   localparam int IMM6_W  = 6;   // Signed, bits 5..0
   localparam int IMM9_W  = 9;   // Signed, bits 8..0

endpackage

// File: verilog/cpu_pkg.sv
// ##########################################################
// Pipeline types of pipe16: ALU operations and the payloads
// carried by the four stage registers
// ##########################################################
package cpu_pkg;

   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_t;

   typedef struct packed {
      isa_pkg::word_t pc_next;
      isa_pkg::word_t instr;      // Zero is a bubble
   } if_id_t;

   typedef struct packed {
      logic             valid;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             branch;
      logic             branch_ne;
      logic             halt;
      logic             illegal;
      logic             alu_src;   // Immediate as operand b
      alu_op_t          alu_op;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t   a;
      isa_pkg::word_t   b;
      isa_pkg::word_t   imm;
      isa_pkg::word_t   pc_next;
   } id_ex_t;

   typedef struct packed {
      logic             valid;
      logic             reg_write;
      logic             mem_read;
      logic             mem_write;
      logic             halt;
      logic             illegal;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t   result;    // ALU value or memory address
      isa_pkg::word_t   store_data;
   } ex_mem_t;

   typedef struct packed {
      logic             valid;
      logic             reg_write;
      logic             halt;
      logic             illegal;
      isa_pkg::reg_idx_t rd;
      isa_pkg::word_t   wb_data;
   } mem_wb_t;

endpackage

// File: verilog/fetch_unit.sv
// ##########################################################
// Fetch stage with the PC, instruction memory and the
// req/ack program loader used while run is low
// ##########################################################
module fetch_unit #(
   parameter int IMEM_DEPTH = 64
) (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           run,
   input  logic           stall,
   input  logic           flush,
   input  logic           halt_seen,
   input  isa_pkg::word_t target,
   input  logic           load_req,
   input  isa_pkg::word_t load_addr,
   input  isa_pkg::word_t load_data,
   output logic           load_ack,
   output isa_pkg::word_t instr,
   output isa_pkg::word_t pc_next,
   output logic           fetch_valid
);

   localparam int AW = $clog2(IMEM_DEPTH);

   isa_pkg::word_t imem [IMEM_DEPTH];
   isa_pkg::word_t pc;
   isa_pkg::word_t pc_sel;
   logic           stopped;      // Set once a HALT is decoded
   logic           load_start;

   assign pc_next     = pc + 16'd2;
   assign instr       = imem[pc[AW:1]];
   assign fetch_valid = run && !stopped && !halt_seen;
   assign load_start  = load_req && !load_ack && !run;

   always_comb begin
      pc_sel = pc_next;
      if (!run)
         pc_sel = '0;
      else if (flush)
         pc_sel = target;       // Branch taken in EX
      else if (stopped || halt_seen || stall)
         pc_sel = pc;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         stopped  <= 1'b0;
         load_ack <= 1'b0;
      end else begin
         pc       <= pc_sel;
         stopped  <= stopped || halt_seen;
         load_ack <= load_ack ? load_req : load_start;   // Four-phase
      end
   end

   always_ff @(posedge clk) begin
      if (load_start)
         imem[load_addr[AW:1]] <= load_data;
   end

   no_load_while_running: assert property (@(posedge clk) disable iff (!arst_n)
      run |-> !load_req)
      else $error("load_req raised while run is high");

   req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(load_req) |-> !load_ack)
      else $error("load_req raised before load_ack dropped");

endmodule

// File: verilog/instr_decode.sv
// ##########################################################
// Decode: opcode to control bits, sign-extended immediates,
// source register usage and illegal opcode detection
// ##########################################################
module instr_decode (
   input  isa_pkg::word_t    instr,
   input  logic              fetch_valid,
   output logic              valid,
   output logic              reg_write,
   output logic              mem_read,
   output logic              mem_write,
   output logic              branch,
   output logic              branch_ne,
   output logic              halt,
   output logic              illegal,
   output logic              alu_src,
   output cpu_pkg::alu_op_t  alu_op,
   output isa_pkg::reg_idx_t rd,
   output isa_pkg::reg_idx_t rs,
   output isa_pkg::reg_idx_t rt,
   output isa_pkg::word_t    imm,
   output logic              uses_rs,
   output logic              uses_rt,
   output logic              uses_rd_src
);

   isa_pkg::opcode_t opc;
   isa_pkg::word_t   imm6;
   isa_pkg::word_t   imm9;

   assign opc = isa_pkg::opcode_t'(instr[isa_pkg::OPC_LSB +: isa_pkg::OPC_W]);
   assign rd  = instr[isa_pkg::RD_LSB +: isa_pkg::REG_IDX_W];
   assign rs  = instr[isa_pkg::RS_LSB +: isa_pkg::REG_IDX_W];
   assign rt  = instr[isa_pkg::RT_LSB +: isa_pkg::REG_IDX_W];

   assign imm6 = {{(isa_pkg::WORD_W - isa_pkg::IMM6_W){instr[isa_pkg::IMM6_W-1]}},
                  instr[isa_pkg::IMM6_W-1:0]};
   assign imm9 = {{(isa_pkg::WORD_W - isa_pkg::IMM9_W){instr[isa_pkg::IMM9_W-1]}},
                  instr[isa_pkg::IMM9_W-1:0]};

   assign valid = fetch_valid;

   always_comb begin
      reg_write   = 1'b0;
      mem_read    = 1'b0;
      mem_write   = 1'b0;
      branch      = 1'b0;
      branch_ne   = 1'b0;
      halt        = 1'b0;
      illegal     = 1'b0;
      alu_src     = 1'b0;
      alu_op      = cpu_pkg::ALU_ADD;
      imm         = imm6;
      uses_rs     = 1'b0;
      uses_rt     = 1'b0;
      uses_rd_src = 1'b0;
      if (fetch_valid) begin
         case (opc)
            isa_pkg::OP_NOP: ;
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_XOR: begin
               reg_write = 1'b1;
               uses_rs   = 1'b1;
               uses_rt   = 1'b1;
               alu_op    = cpu_pkg::alu_op_t'(opc[1:0] - 2'd1);   // 1..4 map to 0..3
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_LD: begin
               reg_write = 1'b1;
               mem_read  = (opc == isa_pkg::OP_LD);
               alu_src   = 1'b1;
               uses_rs   = 1'b1;
            end
            isa_pkg::OP_LBI: begin
               reg_write = 1'b1;
               alu_src   = 1'b1;
               imm       = imm9;   // Operand a reads as zero
            end
            isa_pkg::OP_ST: begin
               mem_write   = 1'b1;
               alu_src     = 1'b1;
               uses_rs     = 1'b1;
               uses_rd_src = 1'b1;   // Store data
            end
            isa_pkg::OP_BEQZ, isa_pkg::OP_BNEZ: begin
               branch      = 1'b1;
               branch_ne   = (opc == isa_pkg::OP_BNEZ);
               imm         = imm9;
               uses_rd_src = 1'b1;
            end
            isa_pkg::OP_HALT: halt = 1'b1;
            default: illegal = 1'b1;
         endcase
      end
   end

endmodule

// File: verilog/reg_file.sv
// ##########################################################
// Register file: eight words, two read ports, one write
// port, with write-to-read bypass in the same cycle
// ##########################################################
module reg_file (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              we,
   input  isa_pkg::reg_idx_t wr_idx,
   input  isa_pkg::reg_idx_t rd_idx_a,
   input  isa_pkg::reg_idx_t rd_idx_b,
   input  isa_pkg::word_t    wr_data,
   output isa_pkg::word_t    rd_data_a,
   output isa_pkg::word_t    rd_data_b
);

   isa_pkg::word_t regs [isa_pkg::NUM_REGS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < isa_pkg::NUM_REGS; i++)
            regs[i] <= '0;
      end else if (we) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // WB result seen by decode in the same cycle
   assign rd_data_a = (we && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
   assign rd_data_b = (we && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

// File: verilog/hazard_unit.sv
// ##########################################################
// RAW hazard check for decode against the EX and MEM
// producers; WB is covered by the register file bypass
// ##########################################################
module hazard_unit (
   input  isa_pkg::reg_idx_t rs,
   input  isa_pkg::reg_idx_t rt,
   input  isa_pkg::reg_idx_t rd,
   input  logic              uses_rs,
   input  logic              uses_rt,
   input  logic              uses_rd_src,
   input  isa_pkg::reg_idx_t ex_dest,
   input  isa_pkg::reg_idx_t mem_dest,
   input  logic              ex_writes,
   input  logic              mem_writes,
   output logic              stall
);

   function automatic logic pending(input isa_pkg::reg_idx_t idx);
      return (ex_writes && ex_dest == idx) || (mem_writes && mem_dest == idx);
   endfunction

   assign stall = (uses_rs     && pending(rs)) ||
                  (uses_rt     && pending(rt)) ||
                  (uses_rd_src && pending(rd));   // ST data, branch test

endmodule

// File: verilog/alu_exec.sv
// ##########################################################
// Execute stage: ALU, load/store address and the branch
// decision with its target
// ##########################################################
module alu_exec (
   input  isa_pkg::word_t   a,
   input  isa_pkg::word_t   b,
   input  isa_pkg::word_t   imm,
   input  isa_pkg::word_t   pc_next,
   input  cpu_pkg::alu_op_t alu_op,
   input  logic             alu_src,
   input  logic             branch,
   input  logic             branch_ne,
   input  logic             valid,
   output isa_pkg::word_t   result,
   output isa_pkg::word_t   store_data,
   output isa_pkg::word_t   target,
   output logic             take_branch
);

   isa_pkg::word_t op_b;
   logic           a_zero;

   assign op_b = alu_src ? imm : b;

   always_comb begin
      case (alu_op)
         cpu_pkg::ALU_SUB: result = a - op_b;
         cpu_pkg::ALU_AND: result = a & op_b;
         cpu_pkg::ALU_XOR: result = a ^ op_b;
         default:          result = a + op_b;   // Also ADDI, LBI, LD/ST address
      endcase
   end

   assign store_data = b;
   assign a_zero     = (a == '0);
   assign target     = pc_next + {imm[isa_pkg::WORD_W-2:0], 1'b0};

   // Bubbles arrive with branch cleared
   assign take_branch = branch && (a_zero != branch_ne);

   branch_from_valid: assert final (!take_branch || valid)
      else $error("branch taken by an invalid EX slot");

endmodule

// File: verilog/stage_reg.sv
// ##########################################################
// Generic pipeline register: load, hold on stall, or clear
// to the all-zero bubble (bubble wins)
// ##########################################################
module stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     hold,
   input  logic     bubble,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         q <= '0;
      else if (bubble)
         q <= '0;
      else if (!hold)
         q <= d;
   end

endmodule

// File: verilog/data_mem.sv
// ##########################################################
// Data memory: word array with synchronous write and
// combinational read, byte address bit 0 ignored
// ##########################################################
module data_mem #(
   parameter int DMEM_DEPTH = 64
) (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           write,
   input  logic           read,
   input  isa_pkg::word_t addr,
   input  isa_pkg::word_t wdata,
   output isa_pkg::word_t rdata
);

   localparam int AW = $clog2(DMEM_DEPTH);

   isa_pkg::word_t mem [DMEM_DEPTH];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++)
            mem[i] <= '0;
      end else if (write) begin
         mem[addr[AW:1]] <= wdata;
      end
   end

   assign rdata = read ? mem[addr[AW:1]] : '0;

endmodule

// File: verilog/cpu_top.sv
// ##########################################################
// pipe16 core top: five stages with their pipeline
// registers, stall and flush control, writeback and the
// retire trace port
// ##########################################################
module cpu_top #(
   parameter int IMEM_DEPTH = 64,
   parameter int DMEM_DEPTH = 64
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              run,
   input  logic              load_req,
   input  isa_pkg::word_t    load_addr,
   input  isa_pkg::word_t    load_data,
   output logic              load_ack,
   output logic              wb_valid,
   output isa_pkg::reg_idx_t wb_rd,
   output isa_pkg::word_t    wb_data,
   output logic              halted,
   output logic              err
);

   cpu_pkg::if_id_t  if_id_d, if_id_q;
   cpu_pkg::id_ex_t  id_ex_d, id_ex_q;
   cpu_pkg::ex_mem_t ex_mem_d, ex_mem_q;
   cpu_pkg::mem_wb_t mem_wb_d, mem_wb_q;

   isa_pkg::word_t    f_instr, f_pc_next, br_target;
   logic              fetch_valid, stall, flush, halt_seen, id_valid;
   logic              dec_valid, dec_reg_write, dec_mem_read, dec_mem_write;
   logic              dec_branch, dec_branch_ne, dec_halt, dec_illegal, dec_alu_src;
   cpu_pkg::alu_op_t  dec_alu_op;
   isa_pkg::reg_idx_t dec_rd, dec_rs, dec_rt, rd_idx_a, rd_idx_b;
   isa_pkg::word_t    dec_imm, rd_data_a, rd_data_b;
   logic              uses_rs, uses_rt, uses_rd_src;
   isa_pkg::word_t    ex_result, ex_store_data, mem_rdata;

   assign halt_seen = dec_valid && dec_halt && !flush;   // Not if flushed by a branch

   fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
      .clk, .arst_n, .run, .stall, .flush, .halt_seen,
      .target(br_target), .load_req, .load_addr, .load_data, .load_ack,
      .instr(f_instr), .pc_next(f_pc_next), .fetch_valid
   );

   assign if_id_d = '{pc_next: f_pc_next, instr: fetch_valid ? f_instr : '0};

   stage_reg #(.payload_t(cpu_pkg::if_id_t)) u_if_id (
      .clk, .arst_n, .hold(stall), .bubble(flush), .d(if_id_d), .q(if_id_q)
   );

   assign id_valid = (if_id_q.instr != '0);   // Zero word is the bubble

   instr_decode u_decode (
      .instr(if_id_q.instr), .fetch_valid(id_valid), .valid(dec_valid),
      .reg_write(dec_reg_write), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
      .branch(dec_branch), .branch_ne(dec_branch_ne), .halt(dec_halt),
      .illegal(dec_illegal), .alu_src(dec_alu_src), .alu_op(dec_alu_op),
      .rd(dec_rd), .rs(dec_rs), .rt(dec_rt), .imm(dec_imm),
      .uses_rs, .uses_rt, .uses_rd_src
   );

   // Port a carries rs or the tested rd, port b rt or the store data
   assign rd_idx_a = uses_rs ? dec_rs : dec_rd;
   assign rd_idx_b = uses_rt ? dec_rt : dec_rd;

   reg_file u_regs (
      .clk, .arst_n, .we(wb_valid), .wr_idx(mem_wb_q.rd),
      .rd_idx_a, .rd_idx_b, .wr_data(mem_wb_q.wb_data), .rd_data_a, .rd_data_b
   );

   hazard_unit u_hazard (
      .rs(dec_rs), .rt(dec_rt), .rd(dec_rd), .uses_rs, .uses_rt, .uses_rd_src,
      .ex_dest(id_ex_q.rd), .mem_dest(ex_mem_q.rd),
      .ex_writes(id_ex_q.valid && id_ex_q.reg_write),
      .mem_writes(ex_mem_q.valid && ex_mem_q.reg_write), .stall
   );

   assign id_ex_d = '{
      valid: dec_valid, reg_write: dec_reg_write, mem_read: dec_mem_read,
      mem_write: dec_mem_write, branch: dec_branch, branch_ne: dec_branch_ne,
      halt: dec_halt, illegal: dec_illegal, alu_src: dec_alu_src, alu_op: dec_alu_op,
      rd: dec_rd, a: (uses_rs || uses_rd_src) ? rd_data_a : '0,   // LBI adds to zero
      b: rd_data_b, imm: dec_imm, pc_next: if_id_q.pc_next
   };

   stage_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
      .clk, .arst_n, .hold(1'b0), .bubble(stall || flush), .d(id_ex_d), .q(id_ex_q)
   );

   alu_exec u_exec (
      .a(id_ex_q.a), .b(id_ex_q.b), .imm(id_ex_q.imm), .pc_next(id_ex_q.pc_next),
      .alu_op(id_ex_q.alu_op), .alu_src(id_ex_q.alu_src), .branch(id_ex_q.branch),
      .branch_ne(id_ex_q.branch_ne), .valid(id_ex_q.valid), .result(ex_result),
      .store_data(ex_store_data), .target(br_target), .take_branch(flush)
   );

   assign ex_mem_d = '{
      valid: id_ex_q.valid, reg_write: id_ex_q.reg_write, mem_read: id_ex_q.mem_read,
      mem_write: id_ex_q.mem_write, halt: id_ex_q.halt, illegal: id_ex_q.illegal,
      rd: id_ex_q.rd, result: ex_result, store_data: ex_store_data
   };

   stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) u_ex_mem (
      .clk, .arst_n, .hold(1'b0), .bubble(1'b0), .d(ex_mem_d), .q(ex_mem_q)
   );

   data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem (
      .clk, .arst_n, .write(ex_mem_q.valid && ex_mem_q.mem_write),
      .read(ex_mem_q.valid && ex_mem_q.mem_read), .addr(ex_mem_q.result),
      .wdata(ex_mem_q.store_data), .rdata(mem_rdata)
   );

   // Writeback select, load data or ALU result
   assign mem_wb_d = '{
      valid: ex_mem_q.valid, reg_write: ex_mem_q.reg_write, halt: ex_mem_q.halt,
      illegal: ex_mem_q.illegal, rd: ex_mem_q.rd,
      wb_data: ex_mem_q.mem_read ? mem_rdata : ex_mem_q.result
   };

   stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) u_mem_wb (
      .clk, .arst_n, .hold(1'b0), .bubble(1'b0), .d(mem_wb_d), .q(mem_wb_q)
   );

   assign wb_valid = mem_wb_q.valid && mem_wb_q.reg_write;
   assign wb_rd    = mem_wb_q.rd;
   assign wb_data  = mem_wb_q.wb_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         if (mem_wb_q.valid && mem_wb_q.halt)
            halted <= 1'b1;
         if (mem_wb_q.valid && mem_wb_q.illegal)
            err <= 1'b1;   // Sticky until reset
      end
   end

   // Fetch stops at decode of HALT, so nothing younger may retire
   no_retire_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
      halted |-> !wb_valid)
      else $error("register write retired after halt");

endmodule

// File: testbench/retire_checker.sv
// ##########################################################
// Retire checker for pipe16: runs each program on an ISA
// reference model and compares every wb_valid beat in order
// ##########################################################
module retire_checker (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              wb_valid,
   input  isa_pkg::reg_idx_t wb_rd,
   input  isa_pkg::word_t    wb_data,
   input  logic              halted,
   input  logic              err
);

   localparam int IMEM_WORDS = 64;
   localparam int DMEM_WORDS = 64;
   localparam int MAX_STEPS  = 256;   // Guards the model against endless loops

   isa_pkg::word_t    prog [IMEM_WORDS];
   isa_pkg::word_t    m_regs [isa_pkg::NUM_REGS];
   isa_pkg::word_t    m_dmem [DMEM_WORDS];
   isa_pkg::reg_idx_t exp_rd [$];
   isa_pkg::word_t    exp_data [$];
   isa_pkg::reg_idx_t next_rd;
   isa_pkg::word_t    next_data;
   bit                exp_err;
   bit                active = 1'b0;
   string             cur_name;
   int                errors = 0;
   int                tests_run = 0;
   int                tests_failed = 0;
   int                test_errors;
   int                beats;

   task automatic set_word(int idx, isa_pkg::word_t w);
      prog[idx] = w;
   endtask

   task automatic report_failure(string msg);
      $display("%s: %s", cur_name, msg);
      errors++;
      test_errors++;
   endtask

   task automatic value_mismatch(string sig, isa_pkg::word_t exp_v, isa_pkg::word_t act_v);
      $display("[ERROR] %s %s: expected 0x%h, actual 0x%h", cur_name, sig, exp_v, act_v);
      errors++;
      test_errors++;
   endtask

   task automatic record_write(isa_pkg::reg_idx_t rd, isa_pkg::word_t val);
      m_regs[rd] = val;
      exp_rd.push_back(rd);
      exp_data.push_back(val);
   endtask

   // Sequential ISA interpreter, one instruction per step
   task automatic build_expected(int len);
      isa_pkg::word_t    w;
      isa_pkg::word_t    s6;
      isa_pkg::word_t    s9;
      isa_pkg::word_t    addr;
      isa_pkg::reg_idx_t rd;
      isa_pkg::reg_idx_t rs;
      isa_pkg::reg_idx_t rt;
      int                pc;
      int                steps;
      bit                stop;
      for (int i = 0; i < isa_pkg::NUM_REGS; i++)
         m_regs[i] = '0;
      for (int i = 0; i < DMEM_WORDS; i++)
         m_dmem[i] = '0;
      pc      = 0;
      steps   = 0;
      stop    = 1'b0;
      exp_err = 1'b0;
      while (!stop) begin
         if (pc / 2 >= len || steps >= MAX_STEPS) begin
            report_failure("reference model left the program without reaching HALT");
            stop = 1'b1;
         end else begin
            w    = prog[pc / 2];
            rd   = w[11:9];
            rs   = w[8:6];
            rt   = w[5:3];
            s6   = {{10{w[5]}}, w[5:0]};
            s9   = {{7{w[8]}}, w[8:0]};
            addr = m_regs[rs] + s6;
            pc   = pc + 2;
            steps++;
            case (w[15:12])
               isa_pkg::OP_NOP:  ;
               isa_pkg::OP_ADD:  record_write(rd, m_regs[rs] + m_regs[rt]);
               isa_pkg::OP_SUB:  record_write(rd, m_regs[rs] - m_regs[rt]);
               isa_pkg::OP_AND:  record_write(rd, m_regs[rs] & m_regs[rt]);
               isa_pkg::OP_XOR:  record_write(rd, m_regs[rs] ^ m_regs[rt]);
               isa_pkg::OP_ADDI: record_write(rd, addr);
               isa_pkg::OP_LBI:  record_write(rd, s9);
               isa_pkg::OP_LD:   record_write(rd, m_dmem[addr[6:1]]);
               isa_pkg::OP_ST:   m_dmem[addr[6:1]] = m_regs[rd];
               isa_pkg::OP_BEQZ: if (m_regs[rd] == '0) pc = pc + 2 * int'($signed(w[8:0]));
               isa_pkg::OP_BNEZ: if (m_regs[rd] != '0) pc = pc + 2 * int'($signed(w[8:0]));
               isa_pkg::OP_HALT: stop = 1'b1;
               default:          exp_err = 1'b1;   // Illegal opcode, no write
            endcase
         end
      end
   endtask

   task automatic begin_test(string name, int len);
      cur_name    = name;
      test_errors = 0;
      beats       = 0;
      exp_rd.delete();
      exp_data.delete();
      build_expected(len);
      active = 1'b1;
   endtask

   task automatic end_test(bit ran);
      active = 1'b0;
      if (ran) begin
         if (exp_rd.size() != 0)
            report_failure($sformatf("%0d expected writes never retired", exp_rd.size()));
         if (err !== exp_err)
            value_mismatch("err", 16'(exp_err), 16'(err));
      end
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      $display("test %s: %s, %0d writes retired", cur_name,
               (test_errors == 0) ? "passed" : "failed", beats);
   endtask

   always @(posedge clk) begin
      if (arst_n && active && wb_valid) begin
         beats++;
         if (halted) begin
            report_failure($sformatf("write to r%0d retired after halted", wb_rd));
         end else if (exp_rd.size() == 0) begin
            report_failure($sformatf("unexpected write to r%0d", wb_rd));
         end else begin
            next_rd   = exp_rd.pop_front();
            next_data = exp_data.pop_front();
            if (wb_rd !== next_rd)
               value_mismatch("wb_rd", 16'(next_rd), 16'(wb_rd));
            if (wb_data !== next_data)
               value_mismatch("wb_data", next_data, wb_data);
         end
      end
   end

endmodule

// File: testbench/tb_cpu.sv
// ##########################################################
// Top testbench of pipe16 that loads each program of the
// table over req/ack, runs it until halted and lets the
// checker compare the retire trace
// ##########################################################
module tb_cpu;

   localparam int NUM_TESTS = 6;
   localparam int MAX_LEN   = 16;
   localparam int ACK_WAIT  = 16;   // Cycles allowed per handshake phase

   logic              clk;
   logic              arst_n;
   logic              run;
   logic              load_req;
   isa_pkg::word_t    load_addr;
   isa_pkg::word_t    load_data;
   logic              load_ack;
   logic              wb_valid;
   isa_pkg::reg_idx_t wb_rd;
   isa_pkg::word_t    wb_data;
   logic              halted;
   logic              err;

   string          test_name [NUM_TESTS];
   isa_pkg::word_t prog_words [NUM_TESTS][MAX_LEN];
   int             prog_len [NUM_TESTS];
   int             watchdog_cycles = 0;
   integer         seed;

   cpu_top #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) uut (
      .clk, .arst_n, .run, .load_req, .load_addr, .load_data, .load_ack,
      .wb_valid, .wb_rd, .wb_data, .halted, .err
   );

   retire_checker chk (
      .clk, .arst_n, .wb_valid, .wb_rd, .wb_data, .halted, .err
   );

   always #50 clk = ~clk;

   function automatic isa_pkg::word_t enc_rrr(isa_pkg::opcode_t op, int rd, int rs, int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
   endfunction

   function automatic isa_pkg::word_t enc_ri6(isa_pkg::opcode_t op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], imm[5:0]};
   endfunction

   function automatic isa_pkg::word_t enc_ri9(isa_pkg::opcode_t op, int rd, int imm);
      return {op, rd[2:0], imm[8:0]};
   endfunction

   task automatic put_word(int t, isa_pkg::word_t w);
      prog_words[t][prog_len[t]] = w;
      prog_len[t]++;
   endtask

   task automatic build_table();
      int rnd;
      seed = 32'h508c_293a;
      for (int t = 0; t < NUM_TESTS; t++)
         prog_len[t] = 0;
      test_name[0] = "alu_basic";
      put_word(0, enc_ri9(isa_pkg::OP_LBI, 1, 25));
      put_word(0, enc_ri9(isa_pkg::OP_LBI, 2, -7));
      put_word(0, enc_ri9(isa_pkg::OP_LBI, 3, 240));
      put_word(0, enc_rrr(isa_pkg::OP_ADD, 4, 1, 2));
      put_word(0, enc_rrr(isa_pkg::OP_SUB, 5, 1, 2));
      put_word(0, enc_rrr(isa_pkg::OP_AND, 6, 3, 1));
      put_word(0, enc_rrr(isa_pkg::OP_XOR, 7, 3, 2));
      put_word(0, enc_ri6(isa_pkg::OP_ADDI, 1, 1, -5));
      put_word(0, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      test_name[1] = "alu_random";
      rnd = $random(seed);
      put_word(1, enc_ri9(isa_pkg::OP_LBI, 1, rnd));
      rnd = $random(seed);
      put_word(1, enc_ri9(isa_pkg::OP_LBI, 2, rnd));
      put_word(1, enc_rrr(isa_pkg::OP_ADD, 3, 1, 2));
      rnd = $random(seed);
      put_word(1, enc_ri6(isa_pkg::OP_ADDI, 4, 3, rnd));
      put_word(1, enc_rrr(isa_pkg::OP_ADD, 5, 4, 1));
      rnd = $random(seed);
      put_word(1, enc_ri6(isa_pkg::OP_ADDI, 6, 2, rnd));
      put_word(1, enc_rrr(isa_pkg::OP_XOR, 7, 5, 6));
      put_word(1, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      test_name[2] = "raw_chain";   // Back-to-back and one-apart producers
      put_word(2, enc_ri9(isa_pkg::OP_LBI, 1, 1));
      put_word(2, enc_ri6(isa_pkg::OP_ADDI, 1, 1, 1));
      put_word(2, enc_ri6(isa_pkg::OP_ADDI, 2, 1, 3));
      put_word(2, enc_ri9(isa_pkg::OP_LBI, 4, 9));
      put_word(2, enc_rrr(isa_pkg::OP_ADD, 3, 2, 1));
      put_word(2, enc_rrr(isa_pkg::OP_SUB, 5, 4, 3));
      put_word(2, enc_rrr(isa_pkg::OP_XOR, 6, 5, 4));
      put_word(2, enc_rrr(isa_pkg::OP_ADD, 0, 6, 6));
      put_word(2, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      test_name[3] = "store_load";
      put_word(3, enc_ri9(isa_pkg::OP_LBI, 1, 85));
      put_word(3, enc_ri9(isa_pkg::OP_LBI, 2, 8));
      put_word(3, enc_ri6(isa_pkg::OP_ST, 1, 2, 2));
      put_word(3, enc_ri6(isa_pkg::OP_LD, 3, 2, 2));
      put_word(3, enc_ri6(isa_pkg::OP_ADDI, 4, 3, 1));
      put_word(3, enc_ri6(isa_pkg::OP_ST, 4, 2, -4));
      put_word(3, enc_ri6(isa_pkg::OP_LD, 5, 2, -4));
      put_word(3, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      test_name[4] = "branches";
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 1, 0));
      put_word(4, enc_ri9(isa_pkg::OP_BEQZ, 1, 2));   // Taken
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 2, 111));
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 3, 222));
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 4, 1));
      put_word(4, enc_ri9(isa_pkg::OP_BNEZ, 4, 2));   // Taken
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 5, 7));
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 6, 8));
      put_word(4, enc_ri9(isa_pkg::OP_BEQZ, 4, 2));   // Falls through
      put_word(4, enc_ri9(isa_pkg::OP_LBI, 7, 3));
      put_word(4, enc_ri9(isa_pkg::OP_BNEZ, 1, 1));   // Falls through
      put_word(4, enc_rrr(isa_pkg::OP_ADD, 2, 4, 7));
      put_word(4, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      test_name[5] = "halt_illegal";
      put_word(5, enc_ri9(isa_pkg::OP_LBI, 1, 4));
      put_word(5, 16'hC000);
      put_word(5, enc_ri6(isa_pkg::OP_ADDI, 2, 1, 2));
      put_word(5, 16'hF1FF);
      put_word(5, enc_ri9(isa_pkg::OP_HALT, 0, 0));
      put_word(5, enc_ri9(isa_pkg::OP_LBI, 3, 9));    // Never retires
      put_word(5, enc_ri9(isa_pkg::OP_LBI, 4, 9));
   endtask

   task automatic reset_dut();
      @(posedge clk);
      arst_n   <= 1'b0;
      run      <= 1'b0;
      load_req <= 1'b0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   task automatic wait_ack(logic level, output bit ok);
      ok = 1'b0;
      for (int n = 0; n < ACK_WAIT && !ok; n++) begin
         @(posedge clk);
         ok = (load_ack === level);
      end
   endtask

   task automatic load_program(int t, output bit ok);
      bit got;
      ok = 1'b1;
      for (int i = 0; i < prog_len[t] && ok; i++) begin
         @(posedge clk);
         load_addr <= 16'(2 * i);
         load_data <= prog_words[t][i];
         load_req  <= 1'b1;
         wait_ack(1'b1, got);
         load_req <= 1'b0;
         if (got)
            wait_ack(1'b0, got);   // Fourth phase
         if (!got) begin
            chk.report_failure($sformatf("load_ack handshake did not complete for word %0d", i));
            ok = 1'b0;
         end
      end
   endtask

   task automatic run_program(int t, output bit done);
      done = 1'b0;
      @(posedge clk);
      run <= 1'b1;
      for (int n = 0; n < prog_len[t] * 8 + 20 && !done; n++) begin
         @(posedge clk);
         done = (halted === 1'b1);
      end
      if (!done)
         chk.report_failure("halted never rose");
      repeat (3) @(posedge clk);   // Late writes would show here
      run <= 1'b0;
   endtask

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("run timed out after %0d cycles", watchdog_cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      bit loaded;
      bit done;
      int total;
      clk       = 1'b0;
      arst_n    = 1'b0;
      run       = 1'b0;
      load_req  = 1'b0;
      load_addr = '0;
      load_data = '0;
      build_table();
      total = 0;
      for (int t = 0; t < NUM_TESTS; t++)
         total += prog_len[t];
      watchdog_cycles = total * 8 + total * 6 + NUM_TESTS * 16;   // Run, load, reset
      for (int t = 0; t < NUM_TESTS; t++) begin
         reset_dut();
         for (int i = 0; i < prog_len[t]; i++)
            chk.set_word(i, prog_words[t][i]);
         chk.begin_test(test_name[t], prog_len[t]);
         load_program(t, loaded);
         done = 1'b0;
         if (loaded)
            run_program(t, done);
         @(negedge clk);
         chk.end_test(done);
      end
      $display("%0d tests run, %0d failed, %0d errors",
               chk.tests_run, chk.tests_failed, chk.errors);
      if (chk.errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: pipe16.f
verilog/isa_pkg.sv
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/alu_exec.sv
verilog/stage_reg.sv
verilog/data_mem.sv
verilog/cpu_top.sv
testbench/retire_checker.sv
testbench/tb_cpu.sv
